//--- include/tb_model.svh
// reference model functions; opcodes outside a lane's set give zero, flags only mean something for compare
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

function automatic simd_pkg::word_t model_lane1(
  input simd_pkg::op_code_e op,
  input simd_pkg::word_t    a,
  input simd_pkg::word_t    b
);
  simd_pkg::word_t r;
  for (int i = 0; i < 2; i++) begin
    case (op)
      simd_pkg::OP_ADD:  r[i] = a[i] + b[i];
      simd_pkg::OP_SUB:  r[i] = a[i] - b[i];
      simd_pkg::OP_RSUB: r[i] = b[i] - a[i];
      simd_pkg::OP_AND:  r[i] = a[i] & b[i];
      simd_pkg::OP_OR:   r[i] = a[i] | b[i];
      simd_pkg::OP_XOR:  r[i] = a[i] ^ b[i];
      simd_pkg::OP_ANDN: r[i] = a[i] & ~b[i];
      simd_pkg::OP_CMP:  r[i] = a[i];
      simd_pkg::OP_SWAP: r[i] = a[1-i];
      simd_pkg::OP_DUP:  r[i] = a[0];
      default:           r[i] = '0;
    endcase
  end
  return r;
endfunction

function automatic simd_pkg::word_t model_lane2(
  input simd_pkg::op_code_e op,
  input simd_pkg::word_t    a,
  input simd_pkg::word_t    b
);
  simd_pkg::word_t r;
  simd_pkg::prod_t p;
  for (int i = 0; i < 2; i++) begin
    p = simd_pkg::prod_t'(a[i]) * simd_pkg::prod_t'(b[i]);
    case (op)
      simd_pkg::OP_MULLO: r[i] = p[simd_pkg::ELEM_W-1:0];
      simd_pkg::OP_MULHI: r[i] = p[2*simd_pkg::ELEM_W-1:simd_pkg::ELEM_W];
      simd_pkg::OP_COPY:  r[i] = a[i];
      default:            r[i] = '0;
    endcase
  end
  return r;
endfunction

// eq bits low, signed lt bits high
function automatic simd_pkg::flags_t model_flags(
  input simd_pkg::word_t a,
  input simd_pkg::word_t b
);
  simd_pkg::flags_t f;
  for (int i = 0; i < 2; i++) begin
    f[i]   = (a[i] == b[i]);
    f[2+i] = ($signed(a[i]) < $signed(b[i]));
  end
  return f;
endfunction

`endif

//--- bench/simd_unit_tb.sv
// directed testbench; expects 2-cycle latency and result registers cleared by reset
`timescale 1ns/1ns

module simd_unit_tb;

  `include "tb_model.svh"

  localparam int NUM_OPS = 29;
  localparam int WATCHDOG_NS = (NUM_OPS * 4 + 100) * 20;

  typedef struct packed {
    simd_pkg::word_t  data;
    logic             cmp;
    simd_pkg::flags_t flg;
    logic [31:0]      cyc;
  } expect_t;

  logic                 clk = 1'b0;
  logic                 rst;
  route_pkg::lane_req_t req1;
  route_pkg::lane_req_t req2;
  route_pkg::lane_res_t res1;
  route_pkg::lane_res_t res2;
  simd_pkg::flags_t     flags;
  logic                 flags_valid;

  logic [31:0]     cyc = '0;
  logic [15:0]     lfsr = 16'd11;
  expect_t         exp1[$];
  expect_t         exp2[$];
  simd_pkg::word_t reg1_model = '0;
  simd_pkg::word_t reg2_model = '0;
  simd_pkg::flags_t flags_exp = '0;
  int              mismatches = 0;
  int              other_errs = 0;

  simd_unit simd_unit_inst (
    .clk         (clk),
    .rst         (rst),
    .req1        (req1),
    .req2        (req2),
    .res1        (res1),
    .res2        (res2),
    .flags       (flags),
    .flags_valid (flags_valid)
  );

  always #10 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 32'd1;

  // taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic simd_pkg::word_t rand_word();
    logic [63:0] bits;
    bits = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[62:0], lfsr[0]};
    end
    return bits;
  endfunction

  function automatic simd_pkg::word_t pair(input simd_pkg::elem_t e1, input simd_pkg::elem_t e0);
    return {e1, e0};
  endfunction

  function automatic route_pkg::lane_req_t make_req(
    input simd_pkg::op_code_e op,
    input simd_pkg::word_t    a,
    input simd_pkg::word_t    b
  );
    route_pkg::lane_req_t r;
    r = '0;
    r.en = 1'b1;
    r.op = op;
    r.a  = a;
    r.b  = b;
    return r;
  endfunction

  // operand as the DUT should see it at the issue edge
  function automatic simd_pkg::word_t operand(
    input route_pkg::fwd_sel_e sel,
    input simd_pkg::word_t     port
  );
    case (sel)
      route_pkg::FWD_LANE1: return reg1_model;
      route_pkg::FWD_LANE2: return reg2_model;
      default:              return port;
    endcase
  endfunction

  task automatic check_word(input string name, input simd_pkg::word_t expv,
                            input simd_pkg::word_t got);
    assert (got == expv) else begin
      $display("mismatch at %0t: %s expected %h got %h", $time, name, expv, got);
      mismatches++;
    end
  endtask

  task automatic check_flags(input string name, input simd_pkg::flags_t expv,
                             input simd_pkg::flags_t got);
    assert (got == expv) else begin
      $display("mismatch at %0t: %s expected %b got %b", $time, name, expv, got);
      mismatches++;
    end
  endtask

  task automatic check_bit(input string name, input logic expv, input logic got);
    assert (got == expv) else begin
      $display("mismatch at %0t: %s expected %b got %b", $time, name, expv, got);
      mismatches++;
    end
  endtask

  task automatic check_latency(input string name, input logic [31:0] issued);
    assert (cyc == issued + 32'd2) else begin
      $display("%0t: %s result came %0d cycles after issue instead of 2",
               $time, name, cyc - issued);
      other_errs++;
    end
  endtask

  task automatic check_outputs();
    expect_t e;
    if (res1.valid) begin
      assert (exp1.size() != 0) else begin
        $display("%0t: res1.valid pulsed with no lane 1 operation outstanding", $time);
        other_errs++;
      end
      if (exp1.size() != 0) begin
        e = exp1.pop_front();
        check_latency("res1", e.cyc);
        check_word("res1.data", e.data, res1.data);
        check_bit("flags_valid", e.cmp, flags_valid);
        reg1_model = e.data;
        if (e.cmp) begin
          flags_exp = e.flg;
        end
      end
    end else begin
      check_bit("flags_valid", 1'b0, flags_valid);
    end
    if (res2.valid) begin
      assert (exp2.size() != 0) else begin
        $display("%0t: res2.valid pulsed with no lane 2 operation outstanding", $time);
        other_errs++;
      end
      if (exp2.size() != 0) begin
        e = exp2.pop_front();
        check_latency("res2", e.cyc);
        check_word("res2.data", e.data, res2.data);
        reg2_model = e.data;
      end
    end
    check_flags("flags", flags_exp, flags);
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      check_outputs();
    end
  end

  // called at a rising edge; returns at the edge where the DUT takes the request
  task automatic issue(input route_pkg::lane_req_t r1, input route_pkg::lane_req_t r2);
    expect_t         e;
    simd_pkg::word_t a;
    simd_pkg::word_t b;
    req1 <= r1;
    req2 <= r2;
    @(posedge clk);
    e = '0;
    e.cyc = cyc;
    if (r1.en) begin
      a = operand(r1.fwd_a, r1.a);
      b = r1.use_bx ? r1.bx : operand(r1.fwd_b, r1.b);
      e.data = model_lane1(r1.op, a, b);
      e.cmp  = (r1.op == simd_pkg::OP_CMP);
      e.flg  = model_flags(a, b);
      exp1.push_back(e);
    end
    if (r2.en) begin
      a = operand(r2.fwd_a, r2.a);
      b = r2.use_bx ? r2.bx : operand(r2.fwd_b, r2.b);
      e.data = model_lane2(r2.op, a, b);
      e.cmp  = 1'b0;
      e.flg  = '0;
      exp2.push_back(e);
    end
  endtask

  task automatic idle();
    req1 <= '0;
    req2 <= '0;
    @(posedge clk);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((exp1.size() != 0 || exp2.size() != 0) && n < 8) begin
      @(posedge clk);
      n++;
    end
    assert (exp1.size() == 0 && exp2.size() == 0) else begin
      $display("%0t: results still missing after %0d cycles of waiting", $time, n);
      other_errs++;
    end
  endtask

  task automatic test_reset_state();
    route_pkg::lane_req_t r1;
    route_pkg::lane_req_t r2;
    @(negedge clk);
    check_bit("res1.valid", 1'b0, res1.valid);
    check_bit("res2.valid", 1'b0, res2.valid);
    check_bit("flags_valid", 1'b0, flags_valid);
    @(posedge clk);
    // forwarding before any issue reads zeroed registers
    r1 = make_req(simd_pkg::OP_ADD, rand_word(), rand_word());
    r1.fwd_a = route_pkg::FWD_LANE1;
    r1.fwd_b = route_pkg::FWD_LANE1;
    r2 = make_req(simd_pkg::OP_COPY, rand_word(), rand_word());
    r2.fwd_a = route_pkg::FWD_LANE2;
    issue(r1, r2);
    idle();
    drain();
  endtask

  task automatic test_lane1_ops();
    simd_pkg::op_code_e ops [10];
    ops = '{simd_pkg::OP_ADD, simd_pkg::OP_SUB, simd_pkg::OP_RSUB, simd_pkg::OP_AND,
            simd_pkg::OP_OR, simd_pkg::OP_XOR, simd_pkg::OP_ANDN, simd_pkg::OP_CMP,
            simd_pkg::OP_SWAP, simd_pkg::OP_DUP};
    foreach (ops[i]) begin
      issue(make_req(ops[i], rand_word(), rand_word()), '0);
    end
    idle();
    drain();
  endtask

  task automatic test_dual_lane();
    simd_pkg::op_code_e mul_ops [3];
    simd_pkg::op_code_e alu_ops [3];
    mul_ops = '{simd_pkg::OP_MULLO, simd_pkg::OP_MULHI, simd_pkg::OP_COPY};
    alu_ops = '{simd_pkg::OP_ADD, simd_pkg::OP_XOR, simd_pkg::OP_RSUB};
    for (int i = 0; i < 6; i++) begin
      issue(make_req(alu_ops[i % 3], rand_word(), rand_word()),
            make_req(mul_ops[i % 3], rand_word(), rand_word()));
    end
    // largest product
    issue(make_req(simd_pkg::OP_SUB, rand_word(), rand_word()),
          make_req(simd_pkg::OP_MULHI, '1, '1));
    idle();
    drain();
  endtask

  task automatic test_compare();
    simd_pkg::word_t la;
    simd_pkg::word_t lb;
    la = pair(32'hFFFF_FFF0, 32'd3);
    lb = pair(32'd2, 32'd7);
    issue(make_req(simd_pkg::OP_CMP, pair(32'd5, 32'd9), pair(32'd5, 32'd9)), '0);
    issue(make_req(simd_pkg::OP_CMP, pair(32'd100, 32'd8), pair(32'hFFFF_FFFF, 32'd1)), '0);
    // last compare leaves both lt bits set
    issue(make_req(simd_pkg::OP_CMP, la, lb), '0);
    issue(make_req(simd_pkg::OP_ADD, rand_word(), rand_word()), '0);
    idle();
    drain();
    check_flags("flags", model_flags(la, lb), flags);
  endtask

  task automatic test_forwarding();
    route_pkg::lane_req_t r1;
    route_pkg::lane_req_t r2;
    issue('0, make_req(simd_pkg::OP_MULLO, rand_word(), rand_word()));
    idle();
    r1 = make_req(simd_pkg::OP_ADD, rand_word(), rand_word());
    r1.fwd_a = route_pkg::FWD_LANE2;
    issue(r1, '0);
    // one cycle too early, still sees the older lane 2 result
    issue('0, make_req(simd_pkg::OP_COPY, rand_word(), rand_word()));
    r1 = make_req(simd_pkg::OP_XOR, rand_word(), rand_word());
    r1.fwd_a = route_pkg::FWD_LANE2;
    r1.fwd_b = route_pkg::FWD_LANE1;
    issue(r1, '0);
    r1 = make_req(simd_pkg::OP_SUB, rand_word(), rand_word());
    r1.bx = rand_word();
    r1.use_bx = 1'b1;
    r1.fwd_b = route_pkg::FWD_LANE1;
    r2 = make_req(simd_pkg::OP_MULLO, rand_word(), rand_word());
    r2.bx = rand_word();
    r2.use_bx = 1'b1;
    r2.fwd_a = route_pkg::FWD_LANE1;
    r2.fwd_b = route_pkg::FWD_LANE2;
    issue(r1, r2);
    idle();
    drain();
  endtask

  task automatic test_wrong_lane();
    issue(make_req(simd_pkg::OP_MULLO, rand_word(), rand_word()),
          make_req(simd_pkg::OP_ADD, rand_word(), rand_word()));
    issue(make_req(simd_pkg::OP_COPY, rand_word(), rand_word()),
          make_req(simd_pkg::OP_CMP, rand_word(), rand_word()));
    idle();
    drain();
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    rst  <= 1'b1;
    req1 <= '0;
    req2 <= '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    test_reset_state();
    test_lane1_ops();
    test_dual_lane();
    test_compare();
    test_forwarding();
    test_wrong_lane();
    $display("summary: %0d mismatches, %0d other errors", mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- hw/alu_lane.sv
// lane 1 execute, combinational; flags_we is raw and must be qualified with the lane valid
`timescale 1ns/1ns

module alu_lane (
  input  simd_pkg::word_t     a,
  input  simd_pkg::word_t     b,
  input  simd_pkg::alu_func_e func,
  output simd_pkg::word_t     res,
  output simd_pkg::flags_t    flags,
  output logic                flags_we
);

  // per element, wraps modulo 2^32
  always_comb begin
    for (int i = 0; i < 2; i++) begin
      case (func)
        simd_pkg::ALU_ADD:  res[i] = a[i] + b[i];
        simd_pkg::ALU_SUB:  res[i] = a[i] - b[i];
        simd_pkg::ALU_RSUB: res[i] = b[i] - a[i];
        simd_pkg::ALU_AND:  res[i] = a[i] & b[i];
        simd_pkg::ALU_OR:   res[i] = a[i] | b[i];
        simd_pkg::ALU_XOR:  res[i] = a[i] ^ b[i];
        simd_pkg::ALU_ANDN: res[i] = a[i] & ~b[i];
        // compare passes A through
        simd_pkg::ALU_CMP:  res[i] = a[i];
        simd_pkg::ALU_SWAP: res[i] = a[1-i];
        simd_pkg::ALU_DUP:  res[i] = a[0];
        default:            res[i] = '0;
      endcase
    end
  end

  // eq in the low two bits, signed lt above
  for (genvar i = 0; i < 2; i++) begin : g_flag
    assign flags[i]   = (a[i] == b[i]);
    assign flags[2+i] = ($signed(a[i]) < $signed(b[i]));
  end

  assign flags_we = (func == simd_pkg::ALU_CMP);

endmodule

//--- hw/mul_lane.sv
// lane 2 execute, combinational; unsigned 32x32 products only, no signed multiply
`timescale 1ns/1ns

module mul_lane (
  input  simd_pkg::word_t     a,
  input  simd_pkg::word_t     b,
  input  simd_pkg::mul_func_e func,
  output simd_pkg::word_t     res
);

  localparam int EW = simd_pkg::ELEM_W;

  simd_pkg::prod_t prod [2];

  for (genvar i = 0; i < 2; i++) begin : g_mul
    assign prod[i] = simd_pkg::prod_t'(a[i]) * simd_pkg::prod_t'(b[i]);
  end

  always_comb begin
    for (int i = 0; i < 2; i++) begin
      case (func)
        simd_pkg::MUL_LO:   res[i] = prod[i][EW-1:0];
        simd_pkg::MUL_HI:   res[i] = prod[i][2*EW-1:EW];
        simd_pkg::MUL_COPY: res[i] = a[i];
        default:            res[i] = '0;
      endcase
    end
  end

endmodule

//--- hw/op_decode.sv
// issue stage; forwarding reads result registers at the issue edge, so dependents need 2 cycles
`timescale 1ns/1ns

module op_decode (
  input  logic                 clk,
  input  logic                 rst,
  input  route_pkg::lane_req_t req1,
  input  route_pkg::lane_req_t req2,
  input  simd_pkg::word_t      fb1,
  input  simd_pkg::word_t      fb2,
  output simd_pkg::word_t      a1,
  output simd_pkg::word_t      b1,
  output simd_pkg::word_t      a2,
  output simd_pkg::word_t      b2,
  output simd_pkg::alu_func_e  alu_func,
  output simd_pkg::mul_func_e  mul_func,
  output logic                 v1,
  output logic                 v2
);

  simd_pkg::word_t opa1;
  simd_pkg::word_t opb1;
  simd_pkg::word_t opa2;
  simd_pkg::word_t opb2;

  function automatic simd_pkg::word_t pick(
    input route_pkg::fwd_sel_e sel,
    input simd_pkg::word_t     port,
    input simd_pkg::word_t     lane1,
    input simd_pkg::word_t     lane2
  );
    case (sel)
      route_pkg::FWD_LANE1: pick = lane1;
      route_pkg::FWD_LANE2: pick = lane2;
      default:              pick = port;
    endcase
  endfunction

  // lane 2 opcodes land on ALU_ZERO
  function automatic simd_pkg::alu_func_e alu_map(input simd_pkg::op_code_e op);
    case (op)
      simd_pkg::OP_ADD:  alu_map = simd_pkg::ALU_ADD;
      simd_pkg::OP_SUB:  alu_map = simd_pkg::ALU_SUB;
      simd_pkg::OP_RSUB: alu_map = simd_pkg::ALU_RSUB;
      simd_pkg::OP_AND:  alu_map = simd_pkg::ALU_AND;
      simd_pkg::OP_OR:   alu_map = simd_pkg::ALU_OR;
      simd_pkg::OP_XOR:  alu_map = simd_pkg::ALU_XOR;
      simd_pkg::OP_ANDN: alu_map = simd_pkg::ALU_ANDN;
      simd_pkg::OP_CMP:  alu_map = simd_pkg::ALU_CMP;
      simd_pkg::OP_SWAP: alu_map = simd_pkg::ALU_SWAP;
      simd_pkg::OP_DUP:  alu_map = simd_pkg::ALU_DUP;
      default:           alu_map = simd_pkg::ALU_ZERO;
    endcase
  endfunction

  function automatic simd_pkg::mul_func_e mul_map(input simd_pkg::op_code_e op);
    case (op)
      simd_pkg::OP_MULLO: mul_map = simd_pkg::MUL_LO;
      simd_pkg::OP_MULHI: mul_map = simd_pkg::MUL_HI;
      simd_pkg::OP_COPY:  mul_map = simd_pkg::MUL_COPY;
      default:            mul_map = simd_pkg::MUL_ZERO;
    endcase
  endfunction

  // bx override wins over fwd_b
  assign opa1 = pick(req1.fwd_a, req1.a, fb1, fb2);
  assign opb1 = req1.use_bx ? req1.bx : pick(req1.fwd_b, req1.b, fb1, fb2);
  assign opa2 = pick(req2.fwd_a, req2.a, fb1, fb2);
  assign opb2 = req2.use_bx ? req2.bx : pick(req2.fwd_b, req2.b, fb1, fb2);

  always_ff @(posedge clk) begin
    if (rst) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
    end else begin
      v1 <= req1.en;
      v2 <= req2.en;
    end
  end

  // operands and functions only move on issue
  always_ff @(posedge clk) begin
    if (req1.en) begin
      a1       <= opa1;
      b1       <= opb1;
      alu_func <= alu_map(req1.op);
    end
    if (req2.en) begin
      a2       <= opa2;
      b2       <= opb2;
      mul_func <= mul_map(req2.op);
    end
  end

endmodule

//--- hw/result_stage.sv
// result registers double as forwarding sources; they only change on a valid lane result
`timescale 1ns/1ns

module result_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 v1,
  input  logic                 v2,
  input  simd_pkg::word_t      r1,
  input  simd_pkg::word_t      r2,
  input  simd_pkg::flags_t     flags_in,
  input  logic                 flags_we,
  output route_pkg::lane_res_t res1,
  output route_pkg::lane_res_t res2,
  output simd_pkg::flags_t     flags,
  output logic                 flags_valid
);

  logic flags_load;

  // only lane 1 can produce flags
  assign flags_load = v1 & flags_we;

  always_ff @(posedge clk) begin
    if (rst) begin
      res1        <= '0;
      res2        <= '0;
      flags       <= '0;
      flags_valid <= 1'b0;
    end else begin
      res1.valid  <= v1;
      res2.valid  <= v2;
      flags_valid <= flags_load;
      if (v1) begin
        res1.data <= r1;
      end
      if (v2) begin
        res2.data <= r2;
      end
      // held until the next compare
      if (flags_load) begin
        flags <= flags_in;
      end
    end
  end

endmodule

//--- hw/route_pkg.sv
// operand routing and lane request/result bundles; forwarding only sees the two lane result registers
package route_pkg;

  // encoding 3 is unused and falls back to the port
  typedef enum logic [1:0] {
    FWD_PORT  = 2'd0,
    FWD_LANE1 = 2'd1,
    FWD_LANE2 = 2'd2
  } fwd_sel_e;

  typedef struct packed {
    logic                en;
    simd_pkg::op_code_e  op;
    simd_pkg::word_t     a;
    simd_pkg::word_t     b;
    simd_pkg::word_t     bx;
    logic                use_bx;
    fwd_sel_e            fwd_a;
    fwd_sel_e            fwd_b;
  } lane_req_t;

  typedef struct packed {
    logic            valid;
    simd_pkg::word_t data;
  } lane_res_t;

endpackage

//--- hw/simd_pkg.sv
// datapath types for the two-lane SIMD unit; widths are fixed, element 0 is the low half of a word
package simd_pkg;

  localparam int ELEM_W = 32;

  typedef logic [ELEM_W-1:0] elem_t;

  // packed pair, index 0 is the low element
  typedef elem_t [1:0] word_t;

  typedef logic [2*ELEM_W-1:0] prod_t;

  // bit 0/1 element equal, bit 2/3 element signed less-than
  typedef logic [3:0] flags_t;

  typedef enum logic [3:0] {
    OP_ADD   = 4'd0,
    OP_SUB   = 4'd1,
    OP_RSUB  = 4'd2,
    OP_AND   = 4'd3,
    OP_OR    = 4'd4,
    OP_XOR   = 4'd5,
    OP_ANDN  = 4'd6,
    OP_CMP   = 4'd7,
    OP_SWAP  = 4'd8,
    OP_DUP   = 4'd9,
    OP_MULLO = 4'd10,
    OP_MULHI = 4'd11,
    OP_COPY  = 4'd12
  } op_code_e;

  // lane 1 functions
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_RSUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_ANDN,
    ALU_CMP,
    ALU_SWAP,
    ALU_DUP,
    ALU_ZERO
  } alu_func_e;

  // lane 2 functions
  typedef enum logic [1:0] {
    MUL_LO,
    MUL_HI,
    MUL_COPY,
    MUL_ZERO
  } mul_func_e;

endpackage

//--- hw/simd_unit.sv
// two-lane packed SIMD unit; 2-cycle latency, no back-pressure, one issue per lane per cycle
`timescale 1ns/1ns

module simd_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  route_pkg::lane_req_t req1,
  input  route_pkg::lane_req_t req2,
  output route_pkg::lane_res_t res1,
  output route_pkg::lane_res_t res2,
  output simd_pkg::flags_t     flags,
  output logic                 flags_valid
);

  simd_pkg::word_t     a1;
  simd_pkg::word_t     b1;
  simd_pkg::word_t     a2;
  simd_pkg::word_t     b2;
  simd_pkg::word_t     r1;
  simd_pkg::word_t     r2;
  simd_pkg::alu_func_e alu_func;
  simd_pkg::mul_func_e mul_func;
  simd_pkg::flags_t    alu_flags;
  logic                alu_flags_we;
  logic                v1;
  logic                v2;

  // result registers loop back as forwarding sources
  op_decode op_decode_inst (
    .clk      (clk),
    .rst      (rst),
    .req1     (req1),
    .req2     (req2),
    .fb1      (res1.data),
    .fb2      (res2.data),
    .a1       (a1),
    .b1       (b1),
    .a2       (a2),
    .b2       (b2),
    .alu_func (alu_func),
    .mul_func (mul_func),
    .v1       (v1),
    .v2       (v2)
  );

  alu_lane alu_lane_inst (
    .a        (a1),
    .b        (b1),
    .func     (alu_func),
    .res      (r1),
    .flags    (alu_flags),
    .flags_we (alu_flags_we)
  );

  mul_lane mul_lane_inst (
    .a    (a2),
    .b    (b2),
    .func (mul_func),
    .res  (r2)
  );

  result_stage result_stage_inst (
    .clk         (clk),
    .rst         (rst),
    .v1          (v1),
    .v2          (v2),
    .r1          (r1),
    .r2          (r2),
    .flags_in    (alu_flags),
    .flags_we    (alu_flags_we),
    .res1        (res1),
    .res2        (res2),
    .flags       (flags),
    .flags_valid (flags_valid)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --assert --top-module simd_unit_tb -f sim.f -o simd_unit_sim \
  && ./obj_dir/simd_unit_sim > sim.log 2>&1 \
  || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0

//--- sim.f
+incdir+include
hw/simd_pkg.sv
hw/route_pkg.sv
hw/op_decode.sv
hw/alu_lane.sv
hw/mul_lane.sv
hw/result_stage.sv
hw/simd_unit.sv
bench/simd_unit_tb.sv
